// ==== include/capture_settings.svh ====
/* Widths, depths and control register bit positions
   shared by the capture path */
`ifndef CAPTURE_SETTINGS_SVH
`define CAPTURE_SETTINGS_SVH

// ------------------------------------------------------------
// Data path widths
// ------------------------------------------------------------
`define CHAN_WIDTH    96    // Live channel A, 8 packed samples
`define WORD_WIDTH    128   // Source and output word
`define SAMPLE_WIDTH  12

// History ring and post phase
`define RING_DEPTH    64
`define RING_AW       6     // log2 of RING_DEPTH
`define POST_LEN      64

`define TRIG_WIDTH    16    // Serialized external trigger

// ------------------------------------------------------------
// Control register bits
// ------------------------------------------------------------
`define CTRL_STREAM_BIT   1   // Counter stream mode
`define CTRL_PATTERN_BIT  2   // Fixed packed pattern
`define CTRL_EXTSRC_BIT   3   // Stream valid from external trigger

`endif

// ==== hw/capture_pkg.sv ====
/* Vector types and the capture state enum of the capture path */
`default_nettype none
`include "capture_settings.svh"

package capture_pkg;

   // ------------------------------------------------------------
   // Data words
   // ------------------------------------------------------------
   typedef logic [`CHAN_WIDTH-1:0] chan_word_t;   // Live channel A
   typedef logic [`WORD_WIDTH-1:0] word_t;        // Source and output

   // ------------------------------------------------------------
   // Ring addressing
   // ------------------------------------------------------------
   typedef logic [`RING_AW-1:0] ring_addr_t;

   // One extra bit so a full count of RING_DEPTH fits
   typedef logic [`RING_AW:0] phase_cnt_t;

   // ------------------------------------------------------------
   // Control and trigger
   // ------------------------------------------------------------
   typedef logic [31:0] ctrl_reg_t;
   typedef logic [`TRIG_WIDTH-1:0] trig_vec_t;   // Serialized, bit 0 oldest

   typedef logic [31:0] count32_t;   // Time and data counters

   // Capture sequence
   typedef enum logic [1:0] {
      FILL,      // Ring not yet full
      ARMED,     // Waiting for trigger
      READOUT,   // History out, oldest first
      POST       // Live words after the history
   } capture_state_t;

endpackage

`default_nettype wire

// ==== hw/ring_if.sv ====
/* Connection between the capture FSM, the ring counter
   and the history ring buffer */
`timescale 1ns/1ns
`default_nettype none

interface ring_if import capture_pkg::*; ();

   // From the FSM
   logic       wr_en;
   logic       rd_en;
   logic       clear;        // Restart counters for a new fill

   // From the counter
   ring_addr_t wr_addr;
   ring_addr_t rd_addr;
   logic       fill_full;
   logic       phase_done;   // Readout or post phase complete

   word_t      rd_word;      // One cycle after rd_en

   modport fsm (output wr_en, rd_en, clear,
                input  fill_full, phase_done, rd_word);

   modport counter (input  wr_en, rd_en, clear,
                    output wr_addr, rd_addr, fill_full, phase_done);

   modport buffer (input  wr_en, rd_en, wr_addr, rd_addr,
                   output rd_word);

endinterface

`default_nettype wire

// ==== hw/trig_sync.sv ====
/* External trigger delay and rising edge detection, trigout
   synchronizers and the control register synchronizer */
`timescale 1ns/1ns
`default_nettype none
`include "capture_settings.svh"

module trig_sync import capture_pkg::*; (
   input  wire            clk_1_8,
   input  wire            rst_i,
   input  wire trig_vec_t ext_trig_vector_i,
   input  wire            trigout_i,
   input  wire            trigout_mcu_i,
   input  wire            trigout_oen_mcu_i,
   input  wire ctrl_reg_t ctrl_reg_i,
   output trig_vec_t      ext_trig_vector_o,
   output logic           ext_trig_o,
   output logic           stream_trig_o,
   output logic           trigout_o,
   output logic           trigout_mcu_o,
   output logic           trigout_oen_o,
   output ctrl_reg_t      ctrl_sync_o
);

   trig_vec_t vec_d1;
   trig_vec_t vec_d2;
   trig_vec_t rise_now;    // Rising bits of the current input
   trig_vec_t rise_det;
   logic      trigout_s1;
   logic      trigout_mcu_s1;
   logic      trigout_oen_s1;
   ctrl_reg_t ctrl_s1;
   ctrl_reg_t ctrl_s2;

   // ------------------------------------------------------------
   // External trigger vector
   // ------------------------------------------------------------
   always_ff @(posedge clk_1_8) begin
      vec_d1            <= ext_trig_vector_i;
      vec_d2            <= vec_d1;
      ext_trig_vector_o <= vec_d2;   // Three cycle copy
   end

   // Bit 0 looks back at the last bit of the previous cycle
   assign rise_now = ext_trig_vector_i &
                     ~{ext_trig_vector_i[`TRIG_WIDTH-2:0], vec_d1[`TRIG_WIDTH-1]};

   always_ff @(posedge clk_1_8) begin
      if (rst_i) begin
         rise_det   <= '0;
         ext_trig_o <= 1'b0;
      end else begin
         rise_det   <= rise_now;
         ext_trig_o <= |rise_det;
      end
   end

   // ------------------------------------------------------------
   // Trigout and control synchronizers
   // ------------------------------------------------------------
   always_ff @(posedge clk_1_8) begin
      trigout_s1     <= trigout_i;
      trigout_mcu_s1 <= trigout_mcu_i;
      trigout_oen_s1 <= trigout_oen_mcu_i;
      trigout_mcu_o  <= trigout_s1;       // Port back into the FPGA
      trigout_o      <= trigout_mcu_s1;
      trigout_oen_o  <= trigout_oen_s1;
      ctrl_s1        <= ctrl_reg_i;
      ctrl_s2        <= ctrl_s1;
      ctrl_sync_o    <= ctrl_s2;
   end

   assign stream_trig_o = trigout_mcu_s1;

   // Back to back pulses need a fresh edge two cycles earlier
   assert property (@(posedge clk_1_8) disable iff (rst_i)
      ext_trig_o && $past(ext_trig_o) |->
         $past(ext_trig_vector_i, 2) !=
         {$past(ext_trig_vector_i[`TRIG_WIDTH-2:0], 2),
          $past(ext_trig_vector_i[`TRIG_WIDTH-1], 3)})
      else $error("ext_trig held without a new rising edge");

endmodule

`default_nettype wire

// ==== hw/source_mux.sv ====
/* Source mode select with time and data counters,
   registered source word and valid */
`timescale 1ns/1ns
`default_nettype none
`include "capture_settings.svh"

module source_mux import capture_pkg::*; (
   input  wire             clk_1_8,
   input  wire             rst_i,
   input  wire ctrl_reg_t  ctrl_i,
   input  wire chan_word_t data_a_i,
   input  wire             data_valid_i,
   input  wire             ext_trig_i,
   input  wire             stream_trig_i,
   output word_t           src_word_o,
   output logic            src_valid_o
);

   localparam int NUM_SAMPLES = `CHAN_WIDTH / `SAMPLE_WIDTH;

   count32_t timecount;
   count32_t datacount;
   logic     stream_mode;
   logic     pattern_mode;
   logic     stream_valid;
   word_t    stream_word;
   word_t    pattern_word;

   assign stream_mode  = ctrl_i[`CTRL_STREAM_BIT];
   assign pattern_mode = ctrl_i[`CTRL_PATTERN_BIT];
   assign stream_valid = ctrl_i[`CTRL_EXTSRC_BIT] ? ext_trig_i : stream_trig_i;

   // 16-bit fields, constants on top and counters below
   assign stream_word = {16'h0007, 16'h0006, 16'h0005, 16'h0004,
                         timecount[31:16], timecount[15:0],
                         datacount[31:16], datacount[15:0]};

   // Sample k holds the value k
   always_comb begin
      pattern_word = '0;
      for (int k = 0; k < NUM_SAMPLES; k++) begin
         pattern_word[k*`SAMPLE_WIDTH +: `SAMPLE_WIDTH] = `SAMPLE_WIDTH'(k);
      end
   end

   // ------------------------------------------------------------
   // Registered source, stream first
   // ------------------------------------------------------------
   always_ff @(posedge clk_1_8) begin
      if (stream_mode)
         src_word_o <= stream_word;
      else if (pattern_mode)
         src_word_o <= pattern_word;
      else
         src_word_o <= word_t'(data_a_i);   // Zero extended live word
   end

   always_ff @(posedge clk_1_8) begin
      if (rst_i) begin
         src_valid_o <= 1'b0;
         timecount   <= '0;
         datacount   <= '0;
      end else begin
         if (stream_mode)
            src_valid_o <= stream_valid;
         else if (pattern_mode)
            src_valid_o <= 1'b1;
         else
            src_valid_o <= data_valid_i;

         if (data_valid_i) timecount <= timecount + 1'b1;

         if (!stream_mode)
            datacount <= '0;                 // Held outside stream mode
         else if (stream_valid)
            datacount <= datacount + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hw/ring_counter.sv ====
/* Write and read pointers, fill count and phase count
   of the history ring */
`timescale 1ns/1ns
`default_nettype none
`include "capture_settings.svh"

module ring_counter import capture_pkg::*; (
   input  wire clk_1_8,
   input  wire rst_i,
   ring_if.counter ring
);

   ring_addr_t wr_ptr;
   ring_addr_t rd_ptr;
   phase_cnt_t fill_cnt;
   phase_cnt_t phase_cnt;
   logic       post_phase;   // Readout done, counting post words

   // ------------------------------------------------------------
   // Pointers and counts
   // ------------------------------------------------------------
   always_ff @(posedge clk_1_8) begin
      if (rst_i || ring.clear) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fill_cnt   <= '0;
         phase_cnt  <= '0;
         post_phase <= 1'b0;
      end else begin
         if (ring.wr_en) wr_ptr <= wr_ptr + 1'b1;

         // Outside readout the read pointer shadows the oldest entry
         if (ring.rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         else if (ring.wr_en)
            rd_ptr <= wr_ptr + 1'b1;

         if (ring.wr_en && !ring.fill_full) fill_cnt <= fill_cnt + 1'b1;

         if (ring.phase_done) begin
            phase_cnt  <= '0;
            post_phase <= 1'b1;
         end else if (ring.rd_en || (post_phase && ring.wr_en)) begin
            phase_cnt  <= phase_cnt + 1'b1;
         end
      end
   end

   assign ring.wr_addr    = wr_ptr;
   assign ring.rd_addr    = rd_ptr;
   assign ring.fill_full  = (fill_cnt == phase_cnt_t'(`RING_DEPTH));
   assign ring.phase_done = post_phase ? (phase_cnt == phase_cnt_t'(`POST_LEN))
                                       : (phase_cnt == phase_cnt_t'(`RING_DEPTH));

   // Single port ring, the FSM must never overlap the two
   assert property (@(posedge clk_1_8) disable iff (rst_i)
      !(ring.rd_en && ring.wr_en))
      else $error("Ring read and write in the same cycle");

endmodule

`default_nettype wire

// ==== hw/ring_buffer.sv ====
/* History RAM of source words, registered read port */
`timescale 1ns/1ns
`default_nettype none
`include "capture_settings.svh"

module ring_buffer import capture_pkg::*; (
   input  wire        clk_1_8,
   input  wire word_t wr_word_i,
   ring_if.buffer     ring
);

   word_t mem [`RING_DEPTH];

   // ------------------------------------------------------------
   // Write port
   // ------------------------------------------------------------
   always_ff @(posedge clk_1_8) begin
      if (ring.wr_en) begin
         mem[ring.wr_addr] <= wr_word_i;
      end
   end

   // ------------------------------------------------------------
   // Read port, data one cycle after rd_en
   // ------------------------------------------------------------
   always_ff @(posedge clk_1_8) begin
      if (ring.rd_en) begin
         ring.rd_word <= mem[ring.rd_addr];
      end
   end

endmodule

`default_nettype wire

// ==== hw/capture_fsm.sv ====
/* Capture state machine driving the ring enables,
   and the output register */
`timescale 1ns/1ns
`default_nettype none
`include "capture_settings.svh"

module capture_fsm import capture_pkg::*; (
   input  wire        clk_1_8,
   input  wire        rst_i,
   input  wire word_t src_word_i,
   input  wire        src_valid_i,
   input  wire        ext_trig_i,
   ring_if.fsm        ring,
   output word_t      data_o,
   output logic       data_valid_o
);

   capture_state_t state;
   capture_state_t state_nxt;
   logic           rd_en_d;     // rd_word valid this cycle
   logic           post_pass;   // Live word goes straight out

   // ------------------------------------------------------------
   // State register and next state
   // ------------------------------------------------------------
   always_ff @(posedge clk_1_8) begin
      if (rst_i)
         state <= FILL;
      else
         state <= state_nxt;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         FILL:    if (ring.fill_full)  state_nxt = ARMED;
         ARMED:   if (ext_trig_i)      state_nxt = READOUT;   // Only here
         READOUT: if (ring.phase_done) state_nxt = POST;
         POST:    if (ring.phase_done) state_nxt = FILL;
         default: state_nxt = FILL;
      endcase
   end

   // Post words also land in the ring so the counter sees them
   assign ring.wr_en = src_valid_i &&
                       (state == FILL || state == ARMED ||
                        (state == POST && !ring.phase_done));
   assign ring.rd_en = (state == READOUT) && !ring.phase_done;
   assign ring.clear = (state == POST) && ring.phase_done;

   assign post_pass = (state == POST) && src_valid_i && !ring.phase_done;

   // ------------------------------------------------------------
   // Output register
   // ------------------------------------------------------------
   always_ff @(posedge clk_1_8) begin
      if (rd_en_d)
         data_o <= ring.rd_word;
      else if (post_pass)
         data_o <= src_word_i;
   end

   always_ff @(posedge clk_1_8) begin
      if (rst_i) begin
         rd_en_d      <= 1'b0;
         data_valid_o <= 1'b0;
      end else begin
         rd_en_d      <= ring.rd_en;
         data_valid_o <= rd_en_d || post_pass;
      end
   end

   // Nothing leaves the block before a trigger
   assert property (@(posedge clk_1_8) disable iff (rst_i)
      (state == FILL || state == ARMED) |-> !data_valid_o)
      else $error("Output valid while not capturing");

endmodule

`default_nettype wire

// ==== hw/capture_top.sv ====
/* Top level of the capture path: trigger sync, source select,
   ring counter, ring buffer and capture FSM */
`timescale 1ns/1ns
`default_nettype none
`include "capture_settings.svh"

module capture_top import capture_pkg::*; (
   input  wire             clk_1_8,
   input  wire             rst_i,
   input  wire chan_word_t data_a_i,
   input  wire             data_valid_i,
   input  wire ctrl_reg_t  ctrl_reg_i,
   input  wire trig_vec_t  ext_trig_vector_i,
   input  wire             trigout_i,
   input  wire             trigout_mcu_i,
   input  wire             trigout_oen_mcu_i,
   output word_t           data_o,
   output logic            data_valid_o,
   output trig_vec_t       ext_trig_vector_o,
   output logic            trigout_o,
   output logic            trigout_mcu_o,
   output logic            trigout_oen_o
);

   logic      ext_trig;
   logic      stream_trig;
   ctrl_reg_t ctrl_sync;
   word_t     src_word;
   logic      src_valid;

   ring_if ring0 ();

   // ------------------------------------------------------------
   // Trigger and control input
   // ------------------------------------------------------------
   trig_sync u_trig_sync (
      .clk_1_8           (clk_1_8),
      .rst_i             (rst_i),
      .ext_trig_vector_i (ext_trig_vector_i),
      .trigout_i         (trigout_i),
      .trigout_mcu_i     (trigout_mcu_i),
      .trigout_oen_mcu_i (trigout_oen_mcu_i),
      .ctrl_reg_i        (ctrl_reg_i),
      .ext_trig_vector_o (ext_trig_vector_o),
      .ext_trig_o        (ext_trig),
      .stream_trig_o     (stream_trig),
      .trigout_o         (trigout_o),
      .trigout_mcu_o     (trigout_mcu_o),
      .trigout_oen_o     (trigout_oen_o),
      .ctrl_sync_o       (ctrl_sync)
   );

   source_mux u_source_mux (
      .clk_1_8       (clk_1_8),
      .rst_i         (rst_i),
      .ctrl_i        (ctrl_sync),
      .data_a_i      (data_a_i),
      .data_valid_i  (data_valid_i),
      .ext_trig_i    (ext_trig),
      .stream_trig_i (stream_trig),
      .src_word_o    (src_word),
      .src_valid_o   (src_valid)
   );

   // ------------------------------------------------------------
   // Capture engine
   // ------------------------------------------------------------
   ring_counter u_ring_counter (
      .clk_1_8 (clk_1_8),
      .rst_i   (rst_i),
      .ring    (ring0.counter)
   );

   ring_buffer u_ring_buffer (
      .clk_1_8   (clk_1_8),
      .wr_word_i (src_word),
      .ring      (ring0.buffer)
   );

   capture_fsm u_capture_fsm (
      .clk_1_8      (clk_1_8),
      .rst_i        (rst_i),
      .src_word_i   (src_word),
      .src_valid_i  (src_valid),
      .ext_trig_i   (ext_trig),
      .ring         (ring0.fsm),
      .data_o       (data_o),
      .data_valid_o (data_valid_o)
   );

endmodule

`default_nettype wire

// ==== verif/capture_tb.sv ====
/* Testbench of the capture path: clock, reset, stimulus,
   reference model, output collector and pass-through monitor */
`timescale 1ns/1ns
`default_nettype none
`include "capture_settings.svh"

module capture_tb import capture_pkg::*; ();

   localparam int TIMEOUT_CYCLES = 400;

   logic       clk_1_8;
   logic       rst_i;
   chan_word_t data_a_i;
   logic       data_valid_i;
   ctrl_reg_t  ctrl_reg_i;
   trig_vec_t  ext_trig_vector_i;
   logic       trigout_i;
   logic       trigout_mcu_i;
   logic       trigout_oen_mcu_i;
   word_t      data_o;
   logic       data_valid_o;
   trig_vec_t  ext_trig_vector_o;
   logic       trigout_o;
   logic       trigout_mcu_o;
   logic       trigout_oen_o;

   word_t      exp_q[$];        // Expected output words, in order
   word_t      pre_q[$];        // Words presented before the trigger
   word_t      post_q[$];
   int         out_cnt;
   int         exp_total;
   logic       mon_on;
   trig_vec_t  vec_hist[3];
   logic [2:0] tout_hist[2];    // {oen, mcu, trigout} inputs

   capture_top dut0 (
      .clk_1_8           (clk_1_8),
      .rst_i             (rst_i),
      .data_a_i          (data_a_i),
      .data_valid_i      (data_valid_i),
      .ctrl_reg_i        (ctrl_reg_i),
      .ext_trig_vector_i (ext_trig_vector_i),
      .trigout_i         (trigout_i),
      .trigout_mcu_i     (trigout_mcu_i),
      .trigout_oen_mcu_i (trigout_oen_mcu_i),
      .data_o            (data_o),
      .data_valid_o      (data_valid_o),
      .ext_trig_vector_o (ext_trig_vector_o),
      .trigout_o         (trigout_o),
      .trigout_mcu_o     (trigout_mcu_o),
      .trigout_oen_o     (trigout_oen_o)
   );

   initial begin
      clk_1_8 = 1'b0;
      forever #4 clk_1_8 = ~clk_1_8;
   end

   // ------------------------------------------------------------
   // Reference model and checks
   // ------------------------------------------------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "capture test stopped");
   endtask

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      if (got !== exp)
         abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
   endtask

   // Last RING_DEPTH words before the trigger, oldest first, then the post words
   function automatic void model_capture(ref word_t hist[$], ref word_t post[$],
                                         ref word_t res[$]);
      int first;
      first = hist.size() - `RING_DEPTH;
      for (int i = first; i < hist.size(); i++)
         res.push_back(hist[i]);
      foreach (post[i])
         res.push_back(post[i]);
   endfunction

   // Eight 12-bit samples, 7 down to 0, zero extended
   function automatic word_t pattern_word();
      return {32'h0, 12'd7, 12'd6, 12'd5, 12'd4, 12'd3, 12'd2, 12'd1, 12'd0};
   endfunction

   // Timecount stays zero, data_valid_i is idle in stream mode
   function automatic word_t stream_word(input int p);
      return {16'h0007, 16'h0006, 16'h0005, 16'h0004, 32'h0, 32'(p)};
   endfunction

   function automatic chan_word_t random_chan();
      return {$urandom(), $urandom(), $urandom()};
   endfunction

   // ------------------------------------------------------------
   // Stimulus helpers
   // ------------------------------------------------------------
   task automatic drive_word(input chan_word_t w);
      @(posedge clk_1_8);
      data_a_i     <= w;
      data_valid_i <= 1'b1;
   endtask

   task automatic stop_words();
      @(posedge clk_1_8);
      data_valid_i <= 1'b0;
   endtask

   // One nonzero cycle after zeros always holds a rising bit
   task automatic send_trig();
      @(posedge clk_1_8);
      ext_trig_vector_i <= trig_vec_t'($urandom_range(16'hffff, 1));
      @(posedge clk_1_8);
      ext_trig_vector_i <= '0;
      repeat (2) @(posedge clk_1_8);
   endtask

   task automatic wait_outputs(input int target);
      int cycles;
      cycles = 0;
      while (out_cnt < target) begin
         @(posedge clk_1_8);
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            abort_run($sformatf("Timed out waiting for output word %0d", out_cnt + 1));
      end
   endtask

   // ------------------------------------------------------------
   // Output collector and pass-through monitor
   // ------------------------------------------------------------
   always @(posedge clk_1_8) begin
      if (data_valid_o === 1'b1) begin
         if (exp_q.size() == 0)
            abort_run("Output word seen while no capture was expected");
         else
            check_value("data_o", data_o, exp_q.pop_front());
         out_cnt++;
      end
   end

   always @(posedge clk_1_8) begin
      if (mon_on) begin
         check_value("ext_trig_vector_o", ext_trig_vector_o, vec_hist[2]);
         check_value("trigout_o", trigout_o, tout_hist[1][1]);   // From the MCU side
         check_value("trigout_mcu_o", trigout_mcu_o, tout_hist[1][0]);
         check_value("trigout_oen_o", trigout_oen_o, tout_hist[1][2]);
      end
      vec_hist[2]  <= vec_hist[1];
      vec_hist[1]  <= vec_hist[0];
      vec_hist[0]  <= ext_trig_vector_i;
      tout_hist[1] <= tout_hist[0];
      tout_hist[0] <= {trigout_oen_mcu_i, trigout_mcu_i, trigout_i};
   end

   // Free running trigout inputs
   initial begin
      trigout_i         = 1'b0;
      trigout_mcu_i     = 1'b0;
      trigout_oen_mcu_i = 1'b0;
      forever begin
         @(posedge clk_1_8);
         trigout_i         <= 1'($urandom());
         trigout_mcu_i     <= 1'($urandom());
         trigout_oen_mcu_i <= 1'($urandom());
      end
   end

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial begin
      chan_word_t w;
      void'($urandom(51277));
      rst_i             = 1'b1;
      data_a_i          = '0;
      data_valid_i      = 1'b0;
      ctrl_reg_i        = '0;          // Live mode
      ext_trig_vector_i = '0;
      out_cnt           = 0;
      exp_total         = 0;
      mon_on            = 1'b0;
      repeat (10) @(posedge clk_1_8);
      rst_i <= 1'b0;
      repeat (4) @(posedge clk_1_8);
      mon_on <= 1'b1;

      // Live capture of 100 words
      for (int i = 0; i < 100; i++) begin
         w = random_chan();
         drive_word(w);
         pre_q.push_back(word_t'(w));
      end
      stop_words();
      for (int i = 0; i < `POST_LEN; i++)
         post_q.push_back(word_t'(random_chan()));
      send_trig();
      model_capture(pre_q, post_q, exp_q);   // History output starts a few cycles later
      exp_total += `RING_DEPTH + `POST_LEN;
      wait_outputs(exp_total - `POST_LEN);
      foreach (post_q[i])
         drive_word(chan_word_t'(post_q[i]));
      stop_words();
      wait_outputs(exp_total);

      // Early trigger, ring not yet refilled
      for (int i = 0; i < 30; i++)
         drive_word(random_chan());
      stop_words();
      send_trig();
      repeat (100) @(posedge clk_1_8);
      check_value("output count", out_cnt, exp_total);

      // Pattern mode
      @(posedge clk_1_8);
      ctrl_reg_i <= ctrl_reg_t'(1) << `CTRL_PATTERN_BIT;
      repeat (100) @(posedge clk_1_8);   // Ring fully rewritten
      pre_q.delete();
      post_q.delete();
      repeat (`RING_DEPTH) pre_q.push_back(pattern_word());
      repeat (`POST_LEN) post_q.push_back(pattern_word());
      send_trig();
      model_capture(pre_q, post_q, exp_q);
      exp_total += `RING_DEPTH + `POST_LEN;
      wait_outputs(exp_total);

      // Stream mode, valids from the external trigger
      @(posedge clk_1_8);
      ctrl_reg_i <= (ctrl_reg_t'(1) << `CTRL_STREAM_BIT) |
                    (ctrl_reg_t'(1) << `CTRL_EXTSRC_BIT);
      repeat (4) @(posedge clk_1_8);
      rst_i <= 1'b1;
      repeat (10) @(posedge clk_1_8);
      rst_i <= 1'b0;
      repeat (4) @(posedge clk_1_8);
      pre_q.delete();
      post_q.delete();
      for (int p = 0; p < `RING_DEPTH; p++)
         pre_q.push_back(stream_word(p));
      // Pulse RING_DEPTH is the trigger, its word lands in READOUT and is dropped
      for (int p = `RING_DEPTH + 1; p <= `RING_DEPTH + `POST_LEN; p++)
         post_q.push_back(stream_word(p));
      repeat (`RING_DEPTH) send_trig();
      send_trig();
      model_capture(pre_q, post_q, exp_q);
      exp_total += `RING_DEPTH + `POST_LEN;
      wait_outputs(exp_total - `POST_LEN);
      repeat (`POST_LEN) send_trig();
      wait_outputs(exp_total);

      repeat (10) @(posedge clk_1_8);
      if (exp_q.size() != 0 || out_cnt != exp_total) begin
         $display("Run ended with %0d expected words not seen", exp_q.size());
         $display("** FAIL **");
         $fatal(1, "capture run incomplete");
      end else begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
hw/capture_pkg.sv
hw/ring_if.sv
hw/trig_sync.sv
hw/source_mux.sv
hw/ring_counter.sv
hw/ring_buffer.sv
hw/capture_fsm.sv
hw/capture_top.sv
verif/capture_tb.sv
